//--- bench/rob_core_cases.txt
# dv wg sn rf dst s1 s2   fd tag rnd value nzcv   a_rdy a_tag b_rdy b_tag f_rdy f_tag
# One cycle per line, hex fields; the expected issue fields belong to this line's dispatch
1 1 1 1 1 2 3   0 0 0 0 0          1 0 1 0 1 0
1 1 0 1 4 1 5   0 0 0 0 0          0 0 1 0 0 0
1 1 0 0 6 4 1   0 0 0 0 0          0 1 0 0 1 0
0 0 0 0 0 0 0   1 1 1 0 5          0 0 0 0 0 0
1 1 0 1 7 4 2   0 0 0 0 0          1 0 1 0 0 0
1 1 1 1 8 1 0   1 0 0 12345678 9   1 0 1 0 1 0
1 1 0 1 9 1 4   0 0 0 0 0          1 0 1 0 0 4
0 0 0 0 0 0 0   1 2 1 0 0          0 0 0 0 0 0
1 1 0 0 1 1 6   0 0 0 0 0          1 0 1 0 1 0
1 1 0 0 a 1 9   1 3 1 0 0          0 6 0 5 1 0
1 1 0 0 7 3 3   0 0 0 0 0          1 0 1 0 1 0
1 1 0 0 b 7 2   0 0 0 0 0          0 0 1 0 1 0
1 1 0 1 c 0 0   0 0 0 0 0          1 0 1 0 0 4
1 1 0 0 d d 0   0 0 0 0 0          1 0 1 0 1 0
0 0 0 0 0 0 0   1 6 1 0 0          0 0 0 0 0 0
0 0 0 0 0 0 0   1 4 1 0 a          0 0 0 0 0 0
0 0 0 0 0 0 0   1 5 1 0 0          0 0 0 0 0 0
1 1 0 1 e 1 8   0 0 0 0 0          1 0 1 0 1 0
0 0 0 0 0 0 0   1 2 1 0 0          0 0 0 0 0 0
0 0 0 0 0 0 0   1 0 0 deadbeef 0   0 0 0 0 0 0
0 0 0 0 0 0 0   1 7 1 0 0          0 0 0 0 0 0
1 1 0 0 f 7 c   1 3 1 0 0          1 0 1 0 1 0
0 0 0 0 0 0 0   1 1 1 0 0          0 0 0 0 0 0
0 0 0 0 0 0 0   1 4 1 0 3          0 0 0 0 0 0
0 0 0 0 0 0 0   1 5 1 0 0          0 0 0 0 0 0

//--- bench/rob_core_tb.sv
`timescale 1ns/1ns

module rob_core_tb
  import rob_pkg::*;
();

  localparam int DRAIN_LIMIT = 100;

  logic                     in_clk = 1'b0;
  logic                     in_rst_n;
  logic                     disp_valid;
  logic [GPR_IDX_WIDTH-1:0] disp_dst;
  logic                     disp_writes_gpr;
  logic                     disp_set_nzcv;
  logic [GPR_IDX_WIDTH-1:0] disp_src1;
  logic [GPR_IDX_WIDTH-1:0] disp_src2;
  logic                     disp_reads_nzcv;
  logic                     fu_done;
  logic [ROB_TAG_WIDTH-1:0] fu_tag;
  logic [GPR_WIDTH-1:0]     fu_value;
  logic [NZCV_WIDTH-1:0]    fu_nzcv;
  logic                     issue_valid;
  logic [ROB_TAG_WIDTH-1:0] issue_tag;
  logic                     issue_a_ready;
  logic [GPR_WIDTH-1:0]     issue_a_value;
  logic [ROB_TAG_WIDTH-1:0] issue_a_tag;
  logic                     issue_b_ready;
  logic [GPR_WIDTH-1:0]     issue_b_value;
  logic [ROB_TAG_WIDTH-1:0] issue_b_tag;
  logic                     issue_f_ready;
  logic [NZCV_WIDTH-1:0]    issue_f_value;
  logic [ROB_TAG_WIDTH-1:0] issue_f_tag;
  logic                     bcast_valid;
  logic [ROB_TAG_WIDTH-1:0] bcast_tag;
  logic [GPR_WIDTH-1:0]     bcast_value;
  logic                     bcast_set_nzcv;
  logic [NZCV_WIDTH-1:0]    bcast_nzcv;
  logic                     commit_valid;
  logic [ROB_TAG_WIDTH-1:0] commit_tag;
  logic                     commit_writes_gpr;
  logic [GPR_IDX_WIDTH-1:0] commit_dst;
  logic [GPR_WIDTH-1:0]     commit_value;
  logic                     commit_set_nzcv;
  logic [NZCV_WIDTH-1:0]    commit_nzcv;
  logic                     rob_full;

  // Fields of the current case line
  logic                     cur_dv, cur_wg, cur_sn, cur_rf, cur_fd, cur_rs;
  logic                     cur_ar, cur_br, cur_fr;
  logic [GPR_IDX_WIDTH-1:0] cur_dst, cur_s1, cur_s2;
  logic [ROB_TAG_WIDTH-1:0] cur_ftag, cur_at, cur_bt, cur_ft;
  logic [GPR_WIDTH-1:0]     cur_fv;
  logic [NZCV_WIDTH-1:0]    cur_fnz;

  // Reference model of committed state, rename table and buffer entries
  logic [GPR_WIDTH-1:0]     m_regs [GPR_COUNT];
  logic [GPR_COUNT-1:0]     m_pend;
  logic [ROB_TAG_WIDTH-1:0] m_ptag [GPR_COUNT];
  logic                     m_fpend;
  logic [ROB_TAG_WIDTH-1:0] m_ftag;
  logic [NZCV_WIDTH-1:0]    m_flags;
  logic [ROB_DEPTH-1:0]     m_done;
  logic [GPR_WIDTH-1:0]     m_val [ROB_DEPTH];
  logic [NZCV_WIDTH-1:0]    m_nz [ROB_DEPTH];
  logic [GPR_IDX_WIDTH-1:0] m_dst [ROB_DEPTH];
  logic                     m_wg [ROB_DEPTH];
  logic                     m_sn [ROB_DEPTH];
  logic [ROB_TAG_WIDTH-1:0] m_next_tag;
  logic [ROB_TAG_WIDTH-1:0] inflight [$];

  // Expected issue and broadcast for the following cycle
  logic                     exp_iv, exp_a_rdy, exp_b_rdy, exp_f_rdy, exp_bv;
  logic [ROB_TAG_WIDTH-1:0] exp_itag, exp_a_tag, exp_b_tag, exp_f_tag, exp_btag;
  logic [GPR_WIDTH-1:0]     exp_a_val, exp_b_val;
  logic [NZCV_WIDTH-1:0]    exp_f_val;

  logic [31:0] rnd_state = 32'h32b7_be17;

  rob_core_top DUT (.*);

  always #5 in_clk = ~in_clk;

  function automatic logic [31:0] next_random();
    rnd_state = rnd_state ^ (rnd_state << 13);
    rnd_state = rnd_state ^ (rnd_state >> 17);
    rnd_state = rnd_state ^ (rnd_state << 5);
    return rnd_state;
  endfunction

  // Newest value of a register, committed or from its producer entry
  function automatic logic [GPR_WIDTH-1:0] model_gpr(input logic [GPR_IDX_WIDTH-1:0] r);
    if (!m_pend[r]) begin
      return m_regs[r];
    end
    return m_val[m_ptag[r]];
  endfunction

  function automatic logic [NZCV_WIDTH-1:0] model_flags();
    if (!m_fpend) begin
      return m_flags;
    end
    return m_nz[m_ftag];
  endfunction

  task automatic report_mismatch(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_full(input logic exp_full);
    if (rob_full !== exp_full) begin
      report_mismatch($sformatf("rob_full %b, expected %b", rob_full, exp_full));
    end
  endtask

  task automatic compare_operand(input string name, input logic got_ready,
      input logic [GPR_WIDTH-1:0] got_value, input logic [ROB_TAG_WIDTH-1:0] got_tag,
      input logic exp_ready, input logic [GPR_WIDTH-1:0] exp_value,
      input logic [ROB_TAG_WIDTH-1:0] exp_tag);
    if (got_ready !== exp_ready) begin
      report_mismatch($sformatf("issue %s ready %b, expected %b", name, got_ready, exp_ready));
    end else if (exp_ready && got_value !== exp_value) begin
      report_mismatch($sformatf("issue %s value %h, expected %h", name, got_value, exp_value));
    end else if (!exp_ready && got_tag !== exp_tag) begin
      report_mismatch($sformatf("issue %s wait tag %0d, expected %0d", name, got_tag, exp_tag));
    end
  endtask

  task automatic check_issue(input logic exp_valid, input logic [ROB_TAG_WIDTH-1:0] exp_tag);
    if (issue_valid !== exp_valid) begin
      report_mismatch($sformatf("issue_valid %b, expected %b", issue_valid, exp_valid));
    end
    if (exp_valid) begin
      if (issue_tag !== exp_tag) begin
        report_mismatch($sformatf("issue_tag %0d, expected %0d", issue_tag, exp_tag));
      end
      compare_operand("a", issue_a_ready, issue_a_value, issue_a_tag,
                      exp_a_rdy, exp_a_val, exp_a_tag);
      compare_operand("b", issue_b_ready, issue_b_value, issue_b_tag,
                      exp_b_rdy, exp_b_val, exp_b_tag);
      compare_operand("flags", issue_f_ready, issue_f_value, issue_f_tag,
                      exp_f_rdy, exp_f_val, exp_f_tag);
    end
  endtask

  task automatic check_bcast(input logic exp_valid, input logic [ROB_TAG_WIDTH-1:0] exp_tag,
      input logic [GPR_WIDTH-1:0] exp_value, input logic exp_set,
      input logic [NZCV_WIDTH-1:0] exp_nzcv);
    if (bcast_valid !== exp_valid) begin
      report_mismatch($sformatf("bcast_valid %b, expected %b", bcast_valid, exp_valid));
    end
    if (exp_valid && (bcast_tag !== exp_tag || bcast_value !== exp_value ||
        bcast_set_nzcv !== exp_set || (exp_set && bcast_nzcv !== exp_nzcv))) begin
      report_mismatch($sformatf("broadcast tag %0d value %h flags %b/%h, expected %0d %h %b/%h",
                                bcast_tag, bcast_value, bcast_set_nzcv, bcast_nzcv,
                                exp_tag, exp_value, exp_set, exp_nzcv));
    end
  endtask

  task automatic check_commit(input logic [ROB_TAG_WIDTH-1:0] exp_tag, input logic exp_wg,
      input logic [GPR_IDX_WIDTH-1:0] exp_dst, input logic [GPR_WIDTH-1:0] exp_value,
      input logic exp_set, input logic [NZCV_WIDTH-1:0] exp_nzcv);
    if (commit_tag !== exp_tag || commit_writes_gpr !== exp_wg || commit_dst !== exp_dst ||
        commit_value !== exp_value || commit_set_nzcv !== exp_set ||
        (exp_set && commit_nzcv !== exp_nzcv)) begin
      report_mismatch($sformatf("commit tag %0d r%0d=%h flags %b/%h, expected %0d r%0d=%h %b/%h",
                                commit_tag, commit_dst, commit_value, commit_set_nzcv,
                                commit_nzcv, exp_tag, exp_dst, exp_value, exp_set, exp_nzcv));
    end
  endtask

  // Drive one cycle of fields, check the outputs and advance the model
  task automatic run_cycle();
    logic [ROB_TAG_WIDTH-1:0] t;
    logic                     found;
    @(posedge in_clk);
    #1;
    disp_valid      = cur_dv;
    disp_dst        = cur_dst;
    disp_writes_gpr = cur_wg;
    disp_set_nzcv   = cur_sn;
    disp_src1       = cur_s1;
    disp_src2       = cur_s2;
    disp_reads_nzcv = cur_rf;
    fu_done         = cur_fd;
    fu_tag          = cur_ftag;
    fu_value        = cur_fv;
    fu_nzcv         = cur_fnz;
    @(negedge in_clk);
    check_full(inflight.size() == ROB_DEPTH);
    check_issue(exp_iv, exp_itag);
    check_bcast(exp_bv, exp_btag, m_val[exp_btag], m_sn[exp_btag], m_nz[exp_btag]);
    if (cur_dv && inflight.size() == ROB_DEPTH) begin
      abort_run("The case file dispatches while the reorder buffer is full");
    end
    if (commit_valid === 1'b1) begin
      if (inflight.size() == 0 || !m_done[inflight[0]]) begin
        report_mismatch("commit_valid high with no finished entry at the head");
      end
      t = inflight.pop_front();
      check_commit(t, m_wg[t], m_dst[t], m_val[t], m_sn[t], m_nz[t]);
      if (m_wg[t]) begin
        m_regs[m_dst[t]] = m_val[t];
        if (m_pend[m_dst[t]] && m_ptag[m_dst[t]] == t) begin
          m_pend[m_dst[t]] = 1'b0;
        end
      end
      if (m_sn[t]) begin
        m_flags = m_nz[t];
        if (m_fpend && m_ftag == t) begin
          m_fpend = 1'b0;
        end
      end
    end else if (commit_valid !== 1'b0) begin
      report_mismatch("commit_valid is unknown");
    end
    if (cur_fd) begin
      found = 1'b0;
      foreach (inflight[i]) begin
        if (inflight[i] == cur_ftag) begin
          found = 1'b1;
        end
      end
      if (!found || m_done[cur_ftag]) begin
        abort_run($sformatf("The case file completes tag %0d, which is not waiting", cur_ftag));
      end
      m_done[cur_ftag] = 1'b1;
      m_val[cur_ftag]  = cur_fv;
      if (m_sn[cur_ftag]) begin
        m_nz[cur_ftag] = cur_fnz;
      end
    end
    exp_bv   = cur_fd;
    exp_btag = cur_ftag;
    // Operands see this cycle's completion and commit, then the new entry is mapped
    exp_iv = cur_dv;
    if (cur_dv) begin
      exp_itag  = m_next_tag;
      exp_a_rdy = cur_ar;
      exp_a_tag = cur_at;
      exp_a_val = model_gpr(cur_s1);
      exp_b_rdy = cur_br;
      exp_b_tag = cur_bt;
      exp_b_val = model_gpr(cur_s2);
      exp_f_rdy = cur_fr;
      exp_f_tag = cur_ft;
      exp_f_val = cur_rf ? model_flags() : '0;
      t = m_next_tag;
      m_done[t] = 1'b0;
      m_nz[t]   = '0;
      m_dst[t]  = cur_dst;
      m_wg[t]   = cur_wg;
      m_sn[t]   = cur_sn;
      if (cur_wg) begin
        m_pend[cur_dst] = 1'b1;
        m_ptag[cur_dst] = t;
      end
      if (cur_sn) begin
        m_fpend = 1'b1;
        m_ftag  = t;
      end
      inflight.push_back(t);
      m_next_tag = m_next_tag + 1'b1;
    end
  endtask

  initial begin
    int    fd;
    int    n;
    int    waited;
    string line;
    in_rst_n = 1'b0;
    {disp_valid, disp_writes_gpr, disp_set_nzcv, disp_reads_nzcv, fu_done} = '0;
    {disp_dst, disp_src1, disp_src2, fu_tag, fu_value, fu_nzcv} = '0;
    {cur_dv, cur_wg, cur_sn, cur_rf, cur_fd, cur_rs, cur_ar, cur_br, cur_fr} = '0;
    {cur_dst, cur_s1, cur_s2, cur_ftag, cur_at, cur_bt, cur_ft, cur_fv, cur_fnz} = '0;
    for (int i = 0; i < GPR_COUNT; i++) begin
      m_regs[i] = '0;
    end
    for (int i = 0; i < ROB_DEPTH; i++) begin
      m_val[i] = '0;
      m_nz[i]  = '0;
      m_sn[i]  = 1'b0;
    end
    {m_pend, m_fpend, m_flags, m_done, m_next_tag, exp_iv, exp_bv, exp_btag} = '0;
    repeat (10) @(posedge in_clk);
    #1;
    in_rst_n = 1'b1;

    fd = $fopen("bench/rob_core_cases.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the case file bench/rob_core_cases.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  cur_dv, cur_wg, cur_sn, cur_rf, cur_dst, cur_s1, cur_s2,
                  cur_fd, cur_ftag, cur_rs, cur_fv, cur_fnz,
                  cur_ar, cur_at, cur_br, cur_bt, cur_fr, cur_ft);
      if (n != 18) begin
        abort_run($sformatf("A case line has %0d fields instead of 18: %s", n, line));
      end
      if (cur_rs) begin
        cur_fv = next_random();
      end
      run_cycle();
    end
    $fclose(fd);

    // Drain until every dispatched entry has retired
    cur_dv = 1'b0;
    cur_fd = 1'b0;
    waited = 0;
    while (inflight.size() != 0 && waited < DRAIN_LIMIT) begin
      run_cycle();
      waited++;
    end
    if (inflight.size() != 0) begin
      abort_run($sformatf("The commit of tag %0d never arrived", inflight[0]));
    end else begin
      run_cycle();
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

//--- common/rob_pkg.sv
package rob_pkg;

  // General register file
  localparam int GPR_COUNT = 16;
  localparam int GPR_IDX_WIDTH = 4;
  localparam int GPR_WIDTH = 32;

  // Flag word holds negative, zero, carry and overflow
  localparam int NZCV_WIDTH = 4;

  // Reorder buffer
  localparam int ROB_DEPTH = 8;
  localparam int ROB_TAG_WIDTH = 3;

endpackage

//--- design/arch_regfile.sv
`timescale 1ns/1ns

module arch_regfile
  import rob_pkg::*;
(
  input  logic                     in_clk,
  input  logic                     in_rst_n,
  input  logic [GPR_IDX_WIDTH-1:0] rf_a_idx,
  input  logic [GPR_IDX_WIDTH-1:0] rf_b_idx,
  output logic [GPR_WIDTH-1:0]     rf_a_value,
  output logic [GPR_WIDTH-1:0]     rf_b_value,
  output logic [NZCV_WIDTH-1:0]    rf_nzcv,
  input  logic                     commit_valid,
  input  logic                     commit_writes_gpr,
  input  logic [GPR_IDX_WIDTH-1:0] commit_dst,
  input  logic [GPR_WIDTH-1:0]     commit_value,
  input  logic                     commit_set_nzcv,
  input  logic [NZCV_WIDTH-1:0]    commit_nzcv
);

  logic [GPR_WIDTH-1:0]  regs [GPR_COUNT];
  logic [NZCV_WIDTH-1:0] nzcv_q;

  logic wr_gpr;
  logic wr_nzcv;

  assign wr_gpr  = commit_valid && commit_writes_gpr;
  assign wr_nzcv = commit_valid && commit_set_nzcv;

  // Reads see a commit landing this cycle
  assign rf_a_value = (wr_gpr && (commit_dst == rf_a_idx)) ? commit_value : regs[rf_a_idx];
  assign rf_b_value = (wr_gpr && (commit_dst == rf_b_idx)) ? commit_value : regs[rf_b_idx];
  assign rf_nzcv    = wr_nzcv ? commit_nzcv : nzcv_q;

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      for (int i = 0; i < GPR_COUNT; i++) begin
        regs[i] <= '0;
      end
      nzcv_q <= '0;
    end else begin
      if (wr_gpr) begin
        regs[commit_dst] <= commit_value;
      end
      if (wr_nzcv) begin
        nzcv_q <= commit_nzcv;
      end
    end
  end

  // Retired entries must have been fully written by their completion
  a_commit_known: assert property (
    @(posedge in_clk) disable iff (!in_rst_n)
    commit_valid |-> !$isunknown({commit_writes_gpr, commit_dst, commit_value,
                                  commit_set_nzcv, commit_nzcv})
  ) else $error("Commit with unknown fields");

endmodule

//--- design/dispatch_rename.sv
`timescale 1ns/1ns

module dispatch_rename
  import rob_pkg::*;
(
  input  logic                     in_clk,
  input  logic                     in_rst_n,
  input  logic                     disp_valid,
  input  logic [GPR_IDX_WIDTH-1:0] disp_dst,
  input  logic                     disp_writes_gpr,
  input  logic                     disp_set_nzcv,
  input  logic [GPR_IDX_WIDTH-1:0] disp_src1,
  input  logic [GPR_IDX_WIDTH-1:0] disp_src2,
  input  logic                     disp_reads_nzcv,
  output logic                     alloc_valid,
  output logic [GPR_IDX_WIDTH-1:0] alloc_dst,
  output logic                     alloc_writes_gpr,
  output logic                     alloc_set_nzcv,
  input  logic [ROB_TAG_WIDTH-1:0] alloc_tag,
  output logic [ROB_TAG_WIDTH-1:0] look_a_tag,
  output logic [ROB_TAG_WIDTH-1:0] look_b_tag,
  output logic [ROB_TAG_WIDTH-1:0] look_f_tag,
  input  logic                     look_a_done,
  input  logic [GPR_WIDTH-1:0]     look_a_value,
  input  logic                     look_b_done,
  input  logic [GPR_WIDTH-1:0]     look_b_value,
  input  logic                     look_f_done,
  input  logic [NZCV_WIDTH-1:0]    look_f_nzcv,
  output logic [GPR_IDX_WIDTH-1:0] rf_a_idx,
  output logic [GPR_IDX_WIDTH-1:0] rf_b_idx,
  input  logic [GPR_WIDTH-1:0]     rf_a_value,
  input  logic [GPR_WIDTH-1:0]     rf_b_value,
  input  logic [NZCV_WIDTH-1:0]    rf_nzcv,
  input  logic                     commit_valid,
  input  logic [ROB_TAG_WIDTH-1:0] commit_tag,
  input  logic [GPR_IDX_WIDTH-1:0] commit_dst,
  input  logic                     commit_writes_gpr,
  input  logic                     commit_set_nzcv,
  output logic                     issue_valid,
  output logic [ROB_TAG_WIDTH-1:0] issue_tag,
  output logic                     issue_a_ready,
  output logic [GPR_WIDTH-1:0]     issue_a_value,
  output logic [ROB_TAG_WIDTH-1:0] issue_a_tag,
  output logic                     issue_b_ready,
  output logic [GPR_WIDTH-1:0]     issue_b_value,
  output logic [ROB_TAG_WIDTH-1:0] issue_b_tag,
  output logic                     issue_f_ready,
  output logic [NZCV_WIDTH-1:0]    issue_f_value,
  output logic [ROB_TAG_WIDTH-1:0] issue_f_tag
);

  // Rename table with one entry per register and one for the flags
  logic [GPR_COUNT-1:0]     pend_gpr;
  logic [ROB_TAG_WIDTH-1:0] tag_gpr [GPR_COUNT];
  logic                     pend_f;
  logic [ROB_TAG_WIDTH-1:0] tag_f;

  logic pend_a;
  logic pend_b;
  logic clear_gpr;
  logic clear_f;

  // Every dispatch takes the next buffer entry
  assign alloc_valid      = disp_valid;
  assign alloc_dst        = disp_dst;
  assign alloc_writes_gpr = disp_writes_gpr;
  assign alloc_set_nzcv   = disp_set_nzcv;

  assign rf_a_idx   = disp_src1;
  assign rf_b_idx   = disp_src2;
  assign look_a_tag = tag_gpr[disp_src1];
  assign look_b_tag = tag_gpr[disp_src2];
  assign look_f_tag = tag_f;

  assign pend_a = pend_gpr[disp_src1];
  assign pend_b = pend_gpr[disp_src2];

  // Commit only frees a mapping that still names the retiring entry
  assign clear_gpr = commit_valid && commit_writes_gpr && pend_gpr[commit_dst] &&
                     (tag_gpr[commit_dst] == commit_tag);
  assign clear_f   = commit_valid && commit_set_nzcv && pend_f && (tag_f == commit_tag);

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      pend_gpr    <= '0;
      pend_f      <= 1'b0;
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= disp_valid;
      if (clear_gpr) begin
        pend_gpr[commit_dst] <= 1'b0;
      end
      if (clear_f) begin
        pend_f <= 1'b0;
      end
      // A new mapping wins over the clear above
      if (disp_valid && disp_writes_gpr) begin
        pend_gpr[disp_dst] <= 1'b1;
      end
      if (disp_valid && disp_set_nzcv) begin
        pend_f <= 1'b1;
      end
    end
  end

  always_ff @(posedge in_clk) begin
    if (disp_valid) begin
      if (disp_writes_gpr) begin
        tag_gpr[disp_dst] <= alloc_tag;
      end
      if (disp_set_nzcv) begin
        tag_f <= alloc_tag;
      end
      issue_tag     <= alloc_tag;
      // Register file, finished buffer entry, or wait on the producer
      issue_a_ready <= !pend_a || look_a_done;
      issue_a_value <= pend_a ? look_a_value : rf_a_value;
      issue_a_tag   <= look_a_tag;
      issue_b_ready <= !pend_b || look_b_done;
      issue_b_value <= pend_b ? look_b_value : rf_b_value;
      issue_b_tag   <= look_b_tag;
      if (!disp_reads_nzcv) begin
        issue_f_ready <= 1'b1;
        issue_f_value <= '0;
        issue_f_tag   <= '0;
      end else begin
        issue_f_ready <= !pend_f || look_f_done;
        issue_f_value <= pend_f ? look_f_nzcv : rf_nzcv;
        issue_f_tag   <= look_f_tag;
      end
    end
  end

endmodule

//--- design/rob_core_top.sv
`timescale 1ns/1ns

module rob_core_top
  import rob_pkg::*;
(
  input  logic                     in_clk,
  input  logic                     in_rst_n,
  input  logic                     disp_valid,
  input  logic [GPR_IDX_WIDTH-1:0] disp_dst,
  input  logic                     disp_writes_gpr,
  input  logic                     disp_set_nzcv,
  input  logic [GPR_IDX_WIDTH-1:0] disp_src1,
  input  logic [GPR_IDX_WIDTH-1:0] disp_src2,
  input  logic                     disp_reads_nzcv,
  input  logic                     fu_done,
  input  logic [ROB_TAG_WIDTH-1:0] fu_tag,
  input  logic [GPR_WIDTH-1:0]     fu_value,
  input  logic [NZCV_WIDTH-1:0]    fu_nzcv,
  output logic                     issue_valid,
  output logic [ROB_TAG_WIDTH-1:0] issue_tag,
  output logic                     issue_a_ready,
  output logic [GPR_WIDTH-1:0]     issue_a_value,
  output logic [ROB_TAG_WIDTH-1:0] issue_a_tag,
  output logic                     issue_b_ready,
  output logic [GPR_WIDTH-1:0]     issue_b_value,
  output logic [ROB_TAG_WIDTH-1:0] issue_b_tag,
  output logic                     issue_f_ready,
  output logic [NZCV_WIDTH-1:0]    issue_f_value,
  output logic [ROB_TAG_WIDTH-1:0] issue_f_tag,
  output logic                     bcast_valid,
  output logic [ROB_TAG_WIDTH-1:0] bcast_tag,
  output logic [GPR_WIDTH-1:0]     bcast_value,
  output logic                     bcast_set_nzcv,
  output logic [NZCV_WIDTH-1:0]    bcast_nzcv,
  output logic                     commit_valid,
  output logic [ROB_TAG_WIDTH-1:0] commit_tag,
  output logic                     commit_writes_gpr,
  output logic [GPR_IDX_WIDTH-1:0] commit_dst,
  output logic [GPR_WIDTH-1:0]     commit_value,
  output logic                     commit_set_nzcv,
  output logic [NZCV_WIDTH-1:0]    commit_nzcv,
  output logic                     rob_full
);

  // Dispatch to buffer allocation
  logic                     alloc_valid;
  logic [GPR_IDX_WIDTH-1:0] alloc_dst;
  logic                     alloc_writes_gpr;
  logic                     alloc_set_nzcv;
  logic [ROB_TAG_WIDTH-1:0] alloc_tag;

  // Operand lookup into the buffer
  logic [ROB_TAG_WIDTH-1:0] look_a_tag;
  logic [ROB_TAG_WIDTH-1:0] look_b_tag;
  logic [ROB_TAG_WIDTH-1:0] look_f_tag;
  logic                     look_a_done;
  logic [GPR_WIDTH-1:0]     look_a_value;
  logic                     look_b_done;
  logic [GPR_WIDTH-1:0]     look_b_value;
  logic                     look_f_done;
  logic [NZCV_WIDTH-1:0]    look_f_nzcv;

  // Committed register reads
  logic [GPR_IDX_WIDTH-1:0] rf_a_idx;
  logic [GPR_IDX_WIDTH-1:0] rf_b_idx;
  logic [GPR_WIDTH-1:0]     rf_a_value;
  logic [GPR_WIDTH-1:0]     rf_b_value;
  logic [NZCV_WIDTH-1:0]    rf_nzcv;

  // Rename, reorder buffer and committed register state
  dispatch_rename u_dispatch_rename (.*);

  rob_buffer u_rob_buffer (.*);

  arch_regfile u_arch_regfile (.*);

endmodule

//--- rob/rob_buffer.sv
`timescale 1ns/1ns

module rob_buffer
  import rob_pkg::*;
(
  input  logic                     in_clk,
  input  logic                     in_rst_n,
  input  logic                     alloc_valid,
  input  logic [GPR_IDX_WIDTH-1:0] alloc_dst,
  input  logic                     alloc_writes_gpr,
  input  logic                     alloc_set_nzcv,
  output logic [ROB_TAG_WIDTH-1:0] alloc_tag,
  input  logic                     fu_done,
  input  logic [ROB_TAG_WIDTH-1:0] fu_tag,
  input  logic [GPR_WIDTH-1:0]     fu_value,
  input  logic [NZCV_WIDTH-1:0]    fu_nzcv,
  input  logic [ROB_TAG_WIDTH-1:0] look_a_tag,
  input  logic [ROB_TAG_WIDTH-1:0] look_b_tag,
  input  logic [ROB_TAG_WIDTH-1:0] look_f_tag,
  output logic                     look_a_done,
  output logic [GPR_WIDTH-1:0]     look_a_value,
  output logic                     look_b_done,
  output logic [GPR_WIDTH-1:0]     look_b_value,
  output logic                     look_f_done,
  output logic [NZCV_WIDTH-1:0]    look_f_nzcv,
  output logic                     bcast_valid,
  output logic [ROB_TAG_WIDTH-1:0] bcast_tag,
  output logic [GPR_WIDTH-1:0]     bcast_value,
  output logic                     bcast_set_nzcv,
  output logic [NZCV_WIDTH-1:0]    bcast_nzcv,
  output logic                     commit_valid,
  output logic [ROB_TAG_WIDTH-1:0] commit_tag,
  output logic                     commit_writes_gpr,
  output logic [GPR_IDX_WIDTH-1:0] commit_dst,
  output logic [GPR_WIDTH-1:0]     commit_value,
  output logic                     commit_set_nzcv,
  output logic [NZCV_WIDTH-1:0]    commit_nzcv,
  output logic                     rob_full
);

  logic [ROB_TAG_WIDTH-1:0] head;
  logic [ROB_TAG_WIDTH-1:0] tail;
  logic [ROB_TAG_WIDTH:0]   count;

  // Entry fields
  logic [ROB_DEPTH-1:0]     ent_done;
  logic [GPR_WIDTH-1:0]     ent_value      [ROB_DEPTH];
  logic [NZCV_WIDTH-1:0]    ent_nzcv       [ROB_DEPTH];
  logic [GPR_IDX_WIDTH-1:0] ent_dst        [ROB_DEPTH];
  logic                     ent_writes_gpr [ROB_DEPTH];
  logic                     ent_set_nzcv   [ROB_DEPTH];

  logic                     hit_a;
  logic                     hit_b;
  logic                     hit_f;
  logic [ROB_TAG_WIDTH-1:0] fu_offset;

  assign alloc_tag = tail;
  assign rob_full  = (count == ROB_DEPTH);

  // Lookups see a completion arriving this cycle
  assign hit_a = fu_done && (fu_tag == look_a_tag);
  assign hit_b = fu_done && (fu_tag == look_b_tag);
  assign hit_f = fu_done && (fu_tag == look_f_tag);

  assign look_a_done  = hit_a || ent_done[look_a_tag];
  assign look_a_value = hit_a ? fu_value : ent_value[look_a_tag];
  assign look_b_done  = hit_b || ent_done[look_b_tag];
  assign look_b_value = hit_b ? fu_value : ent_value[look_b_tag];
  assign look_f_done  = hit_f || ent_done[look_f_tag];
  assign look_f_nzcv  = hit_f ? fu_nzcv : ent_nzcv[look_f_tag];

  // Broadcast reads the entry written at the completion edge
  assign bcast_value    = ent_value[bcast_tag];
  assign bcast_set_nzcv = ent_set_nzcv[bcast_tag];
  assign bcast_nzcv     = ent_nzcv[bcast_tag];

  // Head retires as soon as it is done
  assign commit_valid      = (count != '0) && ent_done[head];
  assign commit_tag        = head;
  assign commit_writes_gpr = ent_writes_gpr[head];
  assign commit_dst        = ent_dst[head];
  assign commit_value      = ent_value[head];
  assign commit_set_nzcv   = ent_set_nzcv[head];
  assign commit_nzcv       = ent_nzcv[head];

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      head        <= '0;
      tail        <= '0;
      count       <= '0;
      ent_done    <= '0;
      bcast_valid <= 1'b0;
    end else begin
      if (alloc_valid) begin
        ent_done[tail] <= 1'b0;
        tail           <= tail + 1'b1;
      end
      if (fu_done) begin
        ent_done[fu_tag] <= 1'b1;
      end
      if (commit_valid) begin
        head <= head + 1'b1;
      end
      count <= count + {{ROB_TAG_WIDTH{1'b0}}, alloc_valid}
                     - {{ROB_TAG_WIDTH{1'b0}}, commit_valid};
      bcast_valid <= fu_done;
    end
  end

  always_ff @(posedge in_clk) begin
    if (alloc_valid) begin
      ent_dst[tail]        <= alloc_dst;
      ent_writes_gpr[tail] <= alloc_writes_gpr;
      ent_set_nzcv[tail]   <= alloc_set_nzcv;
      ent_nzcv[tail]       <= '0;
    end
    if (fu_done) begin
      ent_value[fu_tag] <= fu_value;
      // Flags only kept for flag-setting instructions
      if (ent_set_nzcv[fu_tag]) begin
        ent_nzcv[fu_tag] <= fu_nzcv;
      end
    end
    bcast_tag <= fu_tag;
  end

  // An entry is in flight when its distance from head is below count
  assign fu_offset = fu_tag - head;

  a_no_alloc_when_full: assert property (
    @(posedge in_clk) disable iff (!in_rst_n) alloc_valid |-> !rob_full
  ) else $error("Allocation while the reorder buffer is full");

  a_completion_in_flight: assert property (
    @(posedge in_clk) disable iff (!in_rst_n)
    fu_done |-> ({1'b0, fu_offset} < count) && !ent_done[fu_tag]
  ) else $error("Completion to tag %0d which is not pending", fu_tag);

  a_count_bounded: assert property (
    @(posedge in_clk) disable iff (!in_rst_n) count <= ROB_DEPTH
  ) else $error("Entry count %0d above depth", count);

endmodule

//--- rob_core.f
common/rob_pkg.sv
design/dispatch_rename.sv
rob/rob_buffer.sv
design/arch_regfile.sv
design/rob_core_top.sv
bench/rob_core_tb.sv
